// File: run_sim.sh
#!/bin/sh
# build and run the sniffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f sources.f \
  --top-module tb_n64_ctrl_sniffer -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
  echo "no result line in sim.log"
  exit 1
fi
exit 0

// File: sources.f
+incdir+src
src/sniffer_pkg.sv
src/n64_bit_decoder.sv
src/ctrl_report_capture.sv
src/game_id_capture.sv
src/sniffer_status_hub.sv
src/n64_ctrl_sniffer.sv
tests/tb_n64_ctrl_sniffer.sv

// File: src/ctrl_report_capture.sv
// follows poll frames only: 8 command bits, console stop bit,
// 32 report bits, responder stop bit
// report bits land in order, first received in bit 0
`default_nettype none
`include "sniffer_settings.svh"

module ctrl_report_capture
  import sniffer_pkg::*;
(
  input  logic      CTRL_CLK,
  input  logic      CTRL_nRST,
  input  bit_evt_t  bit_evt_i,
  output ctrl_rep_t rep_o
);

  typedef enum logic [1:0] {
    CAP_IDLE,
    CAP_CMD,
    CAP_PAYLOAD
  } cap_state_t;

  cap_state_t state;
  logic [5:0] bit_cnt;
  logic [6:0] cmd_sr;     // first 7 command bits, last one is taken live
  ctrl_word_t word_sr;

  always_ff @(posedge CTRL_CLK or negedge CTRL_nRST) begin
    if (!CTRL_nRST) begin
      state   <= CAP_IDLE;
      bit_cnt <= 6'd0;
      cmd_sr  <= 7'd0;
      word_sr <= '0;
      rep_o   <= '0;
    end else begin
      rep_o.done <= 1'b0;
      if (bit_evt_i.idle) begin
        state <= CAP_IDLE;      // frame cut short
      end else if (bit_evt_i.sof) begin
        state   <= CAP_CMD;
        bit_cnt <= 6'd0;
      end else if (bit_evt_i.stb) begin
        case (state)
          CAP_CMD: begin
            cmd_sr  <= {cmd_sr[5:0], bit_evt_i.val};
            bit_cnt <= bit_cnt + 6'd1;
            if (bit_cnt == 6'd7) begin
              bit_cnt <= 6'd0;
              state   <= ({cmd_sr, bit_evt_i.val} == `SNIF_CMD_POLL) ? CAP_PAYLOAD
                                                                     : CAP_IDLE;
            end
          end
          CAP_PAYLOAD: begin
            bit_cnt <= bit_cnt + 6'd1;
            if (bit_cnt == 6'd33) begin  // responder stop bit
              state      <= CAP_IDLE;
              rep_o.done <= 1'b1;
              rep_o.ok   <= bit_evt_i.val;
              rep_o.word <= word_sr;
            end else if (bit_cnt != 6'd0) begin  // count 0 is the console stop bit
              word_sr <= {bit_evt_i.val, word_sr[31:1]};
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  a_done_single: assert property (@(posedge CTRL_CLK) disable iff (!CTRL_nRST)
    rep_o.done |=> !rep_o.done);

endmodule

`default_nettype wire

// File: src/game_id_capture.sv
// follows game-id frames only: 8 command bits, console stop bit,
// 80 id bits, responder stop bit
// an all-zero id is reported as not ok
`default_nettype none
`include "sniffer_settings.svh"

module game_id_capture
  import sniffer_pkg::*;
(
  input  logic     CTRL_CLK,
  input  logic     CTRL_nRST,
  input  bit_evt_t bit_evt_i,
  output gid_rep_t rep_o
);

  typedef enum logic [1:0] {
    GID_IDLE,
    GID_CMD,
    GID_PAYLOAD
  } gid_state_t;

  gid_state_t state;
  logic [6:0] bit_cnt;
  logic [6:0] cmd_sr;
  game_id_t   id_sr;

  //////////////////////////////////////////////////////////////////////
  // id bits arrive byte 0 first, MSB first, so shifting in from the
  // bottom leaves byte 0 in bits 79:72 and byte 9 in bits 7:0
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CTRL_CLK or negedge CTRL_nRST) begin
    if (!CTRL_nRST) begin
      state   <= GID_IDLE;
      bit_cnt <= 7'd0;
      cmd_sr  <= 7'd0;
      id_sr   <= '0;
      rep_o   <= '0;
    end else begin
      rep_o.done <= 1'b0;
      if (bit_evt_i.idle) begin
        state <= GID_IDLE;
      end else if (bit_evt_i.sof) begin
        state   <= GID_CMD;
        bit_cnt <= 7'd0;
      end else if (bit_evt_i.stb) begin
        case (state)
          GID_CMD: begin
            cmd_sr  <= {cmd_sr[5:0], bit_evt_i.val};
            bit_cnt <= bit_cnt + 7'd1;
            if (bit_cnt == 7'd7) begin
              bit_cnt <= 7'd0;
              state   <= ({cmd_sr, bit_evt_i.val} == `SNIF_CMD_GAMEID) ? GID_PAYLOAD
                                                                       : GID_IDLE;
            end
          end
          GID_PAYLOAD: begin
            bit_cnt <= bit_cnt + 7'd1;
            if (bit_cnt == 7'd81) begin  // responder stop bit
              state      <= GID_IDLE;
              rep_o.done <= 1'b1;
              rep_o.ok   <= bit_evt_i.val & (|id_sr);
              rep_o.id   <= id_sr;
            end else if (bit_cnt != 7'd0) begin  // skip console stop bit
              id_sr <= {id_sr[78:0], bit_evt_i.val};
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: src/n64_bit_decoder.sv
// line must idle high; a bit cell starts at a falling edge
// bit value is 1 when the low time is shorter than the high time
// events come out 3 cycles after the line edge that decides them
// a bit whose line stays high is closed by a virtual edge
`default_nettype none
`include "sniffer_settings.svh"

module n64_bit_decoder
  import sniffer_pkg::*;
(
  input  logic     CTRL_CLK,
  input  logic     CTRL_nRST,
  input  logic     ctrl_line_i,
  output bit_evt_t bit_evt_o
);

  logic [2:0] line_hist;  // [0] first sync stage, [2] oldest
  logic [7:0] wait_cnt;   // cycles since last edge, saturates
  logic [7:0] low_cnt;
  logic       last_rise;  // line is in the high part of a cell

  logic fall_edge;
  logic rise_edge;
  logic cnt_full;
  logic fall_real;
  logic fall_virt;

  assign fall_edge = line_hist[2] & ~line_hist[1];
  assign rise_edge = ~line_hist[2] & line_hist[1];
  assign cnt_full  = (wait_cnt == `SNIF_IDLE_CYCLES);

  // a real falling edge only ends a bit before the virtual one fired
  assign fall_real = fall_edge & last_rise & (wait_cnt < `SNIF_VIRT_EDGE_TH);
  assign fall_virt = last_rise & ~fall_edge & (wait_cnt == `SNIF_VIRT_EDGE_TH);

  //////////////////////////////////////////////////////////////////////
  // edge timing
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CTRL_CLK or negedge CTRL_nRST) begin
    if (!CTRL_nRST) begin
      line_hist <= 3'b111;
      wait_cnt  <= 8'd0;
      last_rise <= 1'b0;
    end else begin
      line_hist <= {line_hist[1:0], ctrl_line_i};

      if (fall_edge | rise_edge) begin
        wait_cnt <= 8'd0;
      end else if (!cnt_full) begin
        wait_cnt <= wait_cnt + 8'd1;
      end

      if (rise_edge) begin
        last_rise <= 1'b1;
      end else if (fall_edge) begin
        last_rise <= 1'b0;
      end
    end
  end

  // low part of the current cell
  always_ff @(posedge CTRL_CLK) begin
    if (rise_edge) begin
      low_cnt <= wait_cnt;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // event output
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CTRL_CLK or negedge CTRL_nRST) begin
    if (!CTRL_nRST) begin
      bit_evt_o <= '0;
    end else begin
      bit_evt_o.stb  <= fall_real | fall_virt;
      bit_evt_o.val  <= (low_cnt < wait_cnt);   // wait_cnt is the high time here
      bit_evt_o.sof  <= fall_edge & cnt_full;
      bit_evt_o.idle <= line_hist[1] & ~rise_edge &
                        (wait_cnt == (`SNIF_IDLE_CYCLES - 8'd1));
    end
  end

  // a bit decision and the end of a frame never land together
  a_stb_not_idle: assert property (@(posedge CTRL_CLK) disable iff (!CTRL_nRST)
    !(bit_evt_o.stb && bit_evt_o.idle));

endmodule

`default_nettype wire

// File: src/n64_ctrl_sniffer.sv
// controller bus sniffer, all on CTRL_CLK
// ctrl_line_i is the raw bus line, synchronised inside
// n64_rst_drive_o requests the reset line low, no open drain here
`default_nettype none
`include "sniffer_settings.svh"

module n64_ctrl_sniffer
  import sniffer_pkg::*;
#(
  parameter int unsigned RST_PULSE_CYCLES = `SNIF_RST_PULSE_CYCLES
) (
  input  logic       CTRL_CLK,
  input  logic       CTRL_nRST,
  input  logic       ctrl_line_i,
  input  logic       igr_enable_i,
  input  logic       ctrl_ack_i,
  output logic       ctrl_req_o,
  output ctrl_word_t ctrl_word_o,
  output logic       ctrl_detected_o,
  output game_id_t   game_id_o,
  output logic       game_id_valid_o,
  output logic       n64_rst_drive_o
);

  bit_evt_t  bit_evt;
  ctrl_rep_t ctrl_rep;
  gid_rep_t  gid_rep;

  n64_bit_decoder u_bit_decoder (
    .CTRL_CLK    (CTRL_CLK),
    .CTRL_nRST   (CTRL_nRST),
    .ctrl_line_i (ctrl_line_i),
    .bit_evt_o   (bit_evt)
  );

  // both captures watch the same bit stream
  ctrl_report_capture u_ctrl_capture (
    .CTRL_CLK  (CTRL_CLK),
    .CTRL_nRST (CTRL_nRST),
    .bit_evt_i (bit_evt),
    .rep_o     (ctrl_rep)
  );

  game_id_capture u_gid_capture (
    .CTRL_CLK  (CTRL_CLK),
    .CTRL_nRST (CTRL_nRST),
    .bit_evt_i (bit_evt),
    .rep_o     (gid_rep)
  );

  sniffer_status_hub #(
    .RST_PULSE_CYCLES (RST_PULSE_CYCLES)
  ) u_status_hub (
    .CTRL_CLK        (CTRL_CLK),
    .CTRL_nRST       (CTRL_nRST),
    .ctrl_rep_i      (ctrl_rep),
    .gid_rep_i       (gid_rep),
    .igr_enable_i    (igr_enable_i),
    .ctrl_ack_i      (ctrl_ack_i),
    .ctrl_req_o      (ctrl_req_o),
    .ctrl_word_o     (ctrl_word_o),
    .ctrl_detected_o (ctrl_detected_o),
    .game_id_o       (game_id_o),
    .game_id_valid_o (game_id_valid_o),
    .n64_rst_drive_o (n64_rst_drive_o)
  );

endmodule

`default_nettype wire

// File: src/sniffer_pkg.sv
// types shared by the decoder, both captures and the hub
// report word keeps bus order, first received bit in bit 0
// game id keeps byte 0 in the top byte, each byte MSB first
`default_nettype none

package sniffer_pkg;

  typedef logic [31:0] ctrl_word_t;  // buttons 15:0, x axis 23:16, y axis 31:24
  typedef logic [79:0] game_id_t;

  // one entry per CTRL_CLK from the bit decoder
  typedef struct packed {
    logic stb;   // a bit was decided this cycle
    logic val;   // its value, valid with stb
    logic sof;   // first falling edge after an idle line
    logic idle;  // line just reached the idle count
  } bit_evt_t;

  typedef struct packed {
    logic       done;
    logic       ok;    // responder stop bit was 1
    ctrl_word_t word;
  } ctrl_rep_t;

  typedef struct packed {
    logic     done;
    logic     ok;      // good stop bit and id not all zero
    game_id_t id;
  } gid_rep_t;

endpackage

`default_nettype wire

// File: src/sniffer_settings.svh
// timing thresholds are CTRL_CLK cycles at a nominal 4 MHz
// command bytes are compared in bus order, MSB first
// the reset pulse length here is only the default of the hub and top
// parameter RST_PULSE_CYCLES, which must be at least 1
`ifndef SNIFFER_SETTINGS_SVH
`define SNIFFER_SETTINGS_SVH

`define SNIF_VIRT_EDGE_TH      8'd32    // virtual falling edge 8 us after a rise
`define SNIF_IDLE_CYCLES       8'd255   // line high this long ends any frame

`define SNIF_CMD_POLL          8'h01
`define SNIF_CMD_GAMEID        8'h1D

// Z + start + L + R, in report bit order
`define SNIF_IGR_COMBO         16'h0C0C

`define SNIF_RST_PULSE_CYCLES  20'hFFFFF // roughly 260 ms of reset drive

`endif

// File: src/sniffer_status_hub.sv
// partner must answer req with ack and drop ack only after req falls
// one pending report is held while a handshake is open, latest wins
// RST_PULSE_CYCLES must be at least 1 and fit in 20 bits
`default_nettype none
`include "sniffer_settings.svh"

module sniffer_status_hub
  import sniffer_pkg::*;
#(
  parameter int unsigned RST_PULSE_CYCLES = `SNIF_RST_PULSE_CYCLES
) (
  input  logic       CTRL_CLK,
  input  logic       CTRL_nRST,
  input  ctrl_rep_t  ctrl_rep_i,
  input  gid_rep_t   gid_rep_i,
  input  logic       igr_enable_i,
  input  logic       ctrl_ack_i,
  output logic       ctrl_req_o,
  output ctrl_word_t ctrl_word_o,
  output logic       ctrl_detected_o,
  output game_id_t   game_id_o,
  output logic       game_id_valid_o,
  output logic       n64_rst_drive_o
);

  localparam logic [19:0] PULSE_LAST = 20'(RST_PULSE_CYCLES - 1);

  typedef enum logic [1:0] {
    HS_IDLE,
    HS_REQ,
    HS_ACK_LOW   // req dropped, waiting for ack to fall
  } hs_state_t;

  hs_state_t  hs_state;
  ctrl_word_t pend_word;
  logic       pend_vld;
  logic [19:0] rst_cnt;

  logic ok_rep;
  logic hs_free;
  logic igr_hit;

  assign ok_rep  = ctrl_rep_i.done & ctrl_rep_i.ok;
  assign hs_free = ~ctrl_ack_i & ((hs_state == HS_IDLE) | (hs_state == HS_ACK_LOW));
  assign igr_hit = ok_rep & igr_enable_i & (ctrl_rep_i.word[15:0] == `SNIF_IGR_COMBO);

  assign ctrl_req_o = (hs_state == HS_REQ);

  //////////////////////////////////////////////////////////////////////
  // four-phase handshake
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CTRL_CLK or negedge CTRL_nRST) begin
    if (!CTRL_nRST) begin
      hs_state    <= HS_IDLE;
      pend_vld    <= 1'b0;
      pend_word   <= '0;
      ctrl_word_o <= '0;
    end else begin
      if ((hs_state == HS_REQ) && ctrl_ack_i) begin
        hs_state <= HS_ACK_LOW;
      end else if (hs_free && (ok_rep || pend_vld)) begin
        ctrl_word_o <= ok_rep ? ctrl_rep_i.word : pend_word;  // newest first
        pend_vld    <= 1'b0;
        hs_state    <= HS_REQ;
      end else if ((hs_state == HS_ACK_LOW) && !ctrl_ack_i) begin
        hs_state <= HS_IDLE;
      end

      if (ok_rep && !hs_free) begin
        pend_word <= ctrl_rep_i.word;
        pend_vld  <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // status flags and in-game reset
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CTRL_CLK or negedge CTRL_nRST) begin
    if (!CTRL_nRST) begin
      ctrl_detected_o <= 1'b0;
      game_id_o       <= '0;
      game_id_valid_o <= 1'b0;
      n64_rst_drive_o <= 1'b0;
      rst_cnt         <= 20'd0;
    end else begin
      if (ctrl_rep_i.done) begin
        ctrl_detected_o <= ctrl_rep_i.ok;
      end
      if (gid_rep_i.done) begin
        game_id_o       <= gid_rep_i.id;
        game_id_valid_o <= gid_rep_i.ok;
      end

      if (igr_hit) begin
        n64_rst_drive_o <= 1'b1;
        rst_cnt         <= PULSE_LAST;
      end else if (rst_cnt != 20'd0) begin
        rst_cnt <= rst_cnt - 20'd1;
      end else begin
        n64_rst_drive_o <= 1'b0;   // pulse over
      end
    end
  end

  // offered word holds until the partner takes it
  a_word_stable: assert property (@(posedge CTRL_CLK) disable iff (!CTRL_nRST)
    (ctrl_req_o && !ctrl_ack_i) |=> $stable(ctrl_word_o));

endmodule

`default_nettype wire

// File: tests/tb_n64_ctrl_sniffer.sv
// drives whole bus frames at 16 cycles per bit, 270 idle cycles before each
// reset pulse is shortened through the top parameter
// a bad final stop bit is sent with a long low time, since a short low
// followed by an idle line reads as a 1
`default_nettype none
`include "sniffer_settings.svh"

module tb_n64_ctrl_sniffer
  import sniffer_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ns;

  localparam int unsigned PULSE_LEN = 8;
  localparam int FRAMES    = 24;
  localparam int FRAME_CYC = 2500;
  localparam logic [31:0] SEED = 32'h4d9714e6;

  logic CTRL_CLK = 1'b0;
  logic CTRL_nRST;
  logic ctrl_line, igr_enable, ctrl_ack;
  logic ctrl_req, ctrl_detected, game_id_valid, rst_drive;
  ctrl_word_t ctrl_word;
  game_id_t   game_id;

  ctrl_word_t exp_q[$];
  ctrl_word_t got_q[$];
  int   chk_idx = 0;
  int   err_cnt = 0;
  int   chk_cnt = 0;
  int   pulse_cnt = 0;
  int   pulse_len = 0;
  int   run_len = 0;
  bit   hold_ack = 1'b0;
  logic req_q = 1'b0;
  logic [31:0] stim_st = SEED;
  logic [31:0] rsp_st = SEED;

  n64_ctrl_sniffer #(.RST_PULSE_CYCLES(PULSE_LEN)) u_dut (
    .CTRL_CLK (CTRL_CLK), .CTRL_nRST (CTRL_nRST), .ctrl_line_i (ctrl_line),
    .igr_enable_i (igr_enable), .ctrl_ack_i (ctrl_ack), .ctrl_req_o (ctrl_req),
    .ctrl_word_o (ctrl_word), .ctrl_detected_o (ctrl_detected),
    .game_id_o (game_id), .game_id_valid_o (game_id_valid),
    .n64_rst_drive_o (rst_drive)
  );

  always #50 CTRL_CLK = ~CTRL_CLK;

  // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] take_bits(inout logic [31:0] st, input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = st[31] ^ st[21] ^ st[1] ^ st[0];
      st = {st[30:0], fb};
      r  = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic check(input bit cond, input string msg);
    chk_cnt++;
    assert (cond) else begin
      err_cnt++;
      $display("ERR %0t: %s", $time, msg);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // bus waveform
  //////////////////////////////////////////////////////////////////////

  task automatic drive_level(input logic lvl, input int n);
    repeat (n) begin
      ctrl_line <= lvl;
      @(posedge CTRL_CLK);
    end
  endtask

  task automatic send_bit(input logic v, input bit last);
    if (v) begin
      drive_level(1'b0, 4);
      drive_level(1'b1, 12);
    end else begin
      drive_level(1'b0, last ? 40 : 12);
      drive_level(1'b1, 4);
    end
  endtask

  // data goes out data[0] first; line stays high 60 cycles at the end
  task automatic send_frame(input logic [7:0] cmd, input logic [79:0] data,
                            input int nbits, input logic stop, input bit with_stop);
    drive_level(1'b1, 270);
    for (int i = 7; i >= 0; i--) send_bit(cmd[i], 1'b0);
    send_bit(1'b1, 1'b0);   // console stop bit
    for (int i = 0; i < nbits; i++) send_bit(data[i], 1'b0);
    if (with_stop) send_bit(stop, 1'b1);
    drive_level(1'b1, 60);
  endtask

  task automatic run_poll(input ctrl_word_t w, input logic stop);
    send_frame(`SNIF_CMD_POLL, {48'd0, w}, 32, stop, 1'b1);
    if (stop) exp_q.push_back(w);
    check(ctrl_detected == stop, $sformatf("detected %b after stop bit %b",
                                           ctrl_detected, stop));
  endtask

  task automatic run_gid(input game_id_t id, input logic stop);
    logic [79:0] rev;
    for (int i = 0; i < 80; i++) rev[i] = id[79 - i];   // byte 0 MSB goes first
    send_frame(`SNIF_CMD_GAMEID, rev, 80, stop, 1'b1);
  endtask

  // waits until every expected handshake has been seen, then compares
  task automatic wait_words();
    int n;
    n = 0;
    while (got_q.size() < exp_q.size() && n < 3000) begin
      @(posedge CTRL_CLK);
      n++;
    end
    assert (got_q.size() >= exp_q.size()) else begin
      err_cnt++;
      $display("handshake for an expected report never arrived");
    end
    check(got_q.size() <= exp_q.size(), "handshake without a good report");
    while (chk_idx < got_q.size() && chk_idx < exp_q.size()) begin
      check(got_q[chk_idx] == exp_q[chk_idx],
            $sformatf("word %h, expected %h", got_q[chk_idx], exp_q[chk_idx]));
      chk_idx++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // handshake partner and monitors
  //////////////////////////////////////////////////////////////////////

  initial begin
    forever begin
      @(posedge CTRL_CLK);
      if (ctrl_req && !hold_ack) begin
        got_q.push_back(ctrl_word);
        repeat (take_bits(rsp_st, 3)) @(posedge CTRL_CLK);
        ctrl_ack <= 1'b1;
        do @(posedge CTRL_CLK); while (ctrl_req);
        repeat (take_bits(rsp_st, 2)) @(posedge CTRL_CLK);
        ctrl_ack <= 1'b0;
      end
    end
  end

  always @(posedge CTRL_CLK) begin
    if (ctrl_req && !req_q) check(!ctrl_ack, "req rose while ack high");
    if (!ctrl_req && req_q) check(ctrl_ack, "req fell before ack");
    req_q <= ctrl_req;
    if (rst_drive) begin
      run_len = run_len + 1;
    end else if (run_len != 0) begin   // pulse just ended
      pulse_len = run_len;
      pulse_cnt = pulse_cnt + 1;
      run_len = 0;
    end
  end

  initial begin
    #(FRAMES * FRAME_CYC * 100);
    $display("watchdog expired before the tests finished");
    $display("RESULT: FAIL");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    ctrl_word_t  w;
    game_id_t    id;
    logic [115:0] snap;
    int          n_got;
    int          n_pulse;
    CTRL_nRST  = 1'b0;
    ctrl_line  = 1'b1;
    igr_enable = 1'b0;
    ctrl_ack   = 1'b0;
    repeat (4) @(posedge CTRL_CLK);
    CTRL_nRST <= 1'b1;
    check(!ctrl_req && !ctrl_detected && !game_id_valid && !rst_drive, "reset values");

    for (int k = 0; k < 4; k++) begin   // good polls
      run_poll(take_bits(stim_st, 32), 1'b1);
      wait_words();
    end
    run_poll(take_bits(stim_st, 32), 1'b0);   // bad stop bit
    wait_words();

    id = {take_bits(stim_st, 32), take_bits(stim_st, 32), 16'(take_bits(stim_st, 16))};
    id[0] = 1'b1;
    run_gid(id, 1'b1);
    check(game_id == id && game_id_valid, $sformatf("game id %h, expected %h", game_id, id));
    run_gid('0, 1'b1);
    check(!game_id_valid, "valid stays high for zero id");
    run_gid(id, 1'b1);
    check(game_id_valid, "valid low for nonzero id after zero id");
    run_gid(id, 1'b0);
    check(!game_id_valid, "valid stays high after bad stop bit");

    // other commands and a cut frame must leave the outputs alone
    snap  = {ctrl_req, ctrl_word, ctrl_detected, game_id, game_id_valid, rst_drive};
    n_got = got_q.size();
    send_frame(8'h55, {48'd0, take_bits(stim_st, 32)}, 32, 1'b1, 1'b1);
    send_frame(8'h1C, {take_bits(stim_st, 32), take_bits(stim_st, 32),
                       16'(take_bits(stim_st, 16))}, 80, 1'b1, 1'b1);
    send_frame(`SNIF_CMD_POLL, {70'd0, 10'(take_bits(stim_st, 10))}, 10, 1'b1, 1'b0);
    check(snap == {ctrl_req, ctrl_word, ctrl_detected, game_id, game_id_valid, rst_drive},
          "outputs changed on ignored frame");
    check(got_q.size() == n_got, "handshake on ignored frame");

    // ack held off, so the pending slot keeps only the latest report
    hold_ack = 1'b1;
    w = take_bits(stim_st, 32);
    send_frame(`SNIF_CMD_POLL, {48'd0, w}, 32, 1'b1, 1'b1);
    exp_q.push_back(w);
    send_frame(`SNIF_CMD_POLL, {48'd0, take_bits(stim_st, 32)}, 32, 1'b1, 1'b1);
    w = take_bits(stim_st, 32);
    send_frame(`SNIF_CMD_POLL, {48'd0, w}, 32, 1'b1, 1'b1);
    exp_q.push_back(w);
    hold_ack = 1'b0;
    wait_words();

    // in-game reset combo, enabled then disabled
    n_pulse    = pulse_cnt;
    igr_enable <= 1'b1;
    run_poll({16'(take_bits(stim_st, 16)), `SNIF_IGR_COMBO}, 1'b1);
    wait_words();
    check(pulse_cnt == n_pulse + 1, "no reset pulse for combo");
    check(pulse_len == PULSE_LEN, $sformatf("reset pulse %0d cycles", pulse_len));
    igr_enable <= 1'b0;
    run_poll({16'(take_bits(stim_st, 16)), `SNIF_IGR_COMBO}, 1'b1);
    wait_words();
    check(pulse_cnt == n_pulse + 1, "reset pulse with igr disabled");

    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
